// ==== design/ad7606_ctrl.sv ====
// ******************************
// parallel read mode only; range, os, par/ser and stby# are strapped on board.
// hold usr_trigger low until usr_reset_done is high.
// ******************************
`timescale 1ns/1ps
`default_nettype none

module ad7606_ctrl #(
    parameter int clk_period_ns     = 20,   // usr_clk period.
    parameter int t_reset_ns        = 50,   // reset pulse width.
    parameter int t1_ns             = 40,   // convst high to busy high.
    parameter int t2_ns             = 25,   // min convst low.
    parameter int t10_ns            = 25,   // rd# low time.
    parameter int t11_ns            = 15,   // rd# high time.
    parameter int t14_ns            = 25,   // rd# low to data valid.
    parameter int busy_max_ns       = 200,  // busy timeout.
    parameter int first_data_max_ns = 200   // firstdata timeout.
) (
    input  wire                   usr_clk,
    input  wire                   usr_rst,
    input  wire                   usr_trigger,
    output ad7606_pkg::sample_t   usr_channel [ad7606_pkg::num_channels],
    output logic                  usr_complete,
    output logic                  usr_error,
    output logic                  usr_sampling,
    output logic                  usr_reset_done,
    input  wire                   hw_busy,
    input  wire                   hw_first_data,
    input  wire ad7606_pkg::sample_t hw_data,
    output logic                  hw_convst,
    output logic                  hw_rd,
    output logic                  hw_cs,
    output logic                  hw_reset
);
    import ad7606_pkg::*;

    // ******************************
    // timing in clock ticks.
    // ******************************
    localparam tick_t t_reset_ticks   = tick_t'(ns_to_ticks(t_reset_ns, clk_period_ns));
    localparam tick_t t1_ticks        = tick_t'(ns_to_ticks(t1_ns, clk_period_ns));
    localparam tick_t t2_ticks        = tick_t'(ns_to_ticks(t2_ns, clk_period_ns));
    localparam tick_t t10_ticks       = tick_t'(ns_to_ticks(t10_ns, clk_period_ns));
    localparam tick_t t11_ticks       = tick_t'(ns_to_ticks(t11_ns, clk_period_ns));
    localparam tick_t t14_ticks       = tick_t'(ns_to_ticks(t14_ns, clk_period_ns));
    localparam tick_t busy_max_ticks  = tick_t'(ns_to_ticks(busy_max_ns, clk_period_ns));
    localparam tick_t fd_max_ticks    = tick_t'(ns_to_ticks(first_data_max_ns, clk_period_ns));

    logic trigger_rise;                     // one cycle pulse.
    logic busy_s;                           // synced busy.
    logic first_data_s;                     // synced firstdata.
    logic read_start;                       // sequencer to reader.
    logic read_done;                        // all words captured.
    logic read_err;                         // firstdata timeout.

    input_sync u_input_sync (
        .usr_clk, .usr_rst, .usr_trigger, .hw_busy, .hw_first_data,
        .trigger_rise, .busy_s, .first_data_s
    );

    chip_reset_gen #(.t_reset_ticks(t_reset_ticks)) u_chip_reset_gen (
        .usr_clk, .usr_rst, .hw_reset, .reset_done(usr_reset_done)
    );

    conv_sequencer #(
        .t1_ticks(t1_ticks), .t2_ticks(t2_ticks), .busy_max_ticks(busy_max_ticks)
    ) u_conv_sequencer (
        .usr_clk, .usr_rst, .trigger_rise, .reset_done(usr_reset_done), .busy_s,
        .read_done, .read_err, .hw_convst, .hw_cs, .read_start,
        .usr_complete, .usr_error, .usr_sampling
    );

    parallel_reader #(
        .t10_ticks(t10_ticks), .t11_ticks(t11_ticks), .t14_ticks(t14_ticks),
        .first_data_max_ticks(fd_max_ticks)
    ) u_parallel_reader (
        .usr_clk, .usr_rst, .read_start, .first_data_s, .hw_data,
        .hw_rd, .usr_channel, .read_done, .read_err
    );

endmodule

`default_nettype wire

// ==== design/ad7606_pkg.sv ====
// ******************************
// shared types for the ad7606 parallel controller.
// tick counts are 8 bits; keep timing parameters below 255 clocks.
// ******************************
`default_nettype none

package ad7606_pkg;

    localparam int num_channels = 8;                // v1..v8.

    typedef logic [15:0] sample_t;                  // one conversion word.
    typedef logic [3:0]  chan_idx_t;                // must reach 8 for end of read.
    typedef logic [7:0]  tick_t;                    // delay and timeout counts.

    typedef enum logic [2:0] {
        seq_idle, seq_convst_low, seq_busy_rise_wait, seq_busy_fall_wait, seq_reading
    } seq_state_t;

    typedef enum logic [2:0] {
        rd_idle, rd_high, rd_data_settle, rd_capture, rd_low_hold
    } read_state_t;

    typedef enum logic [1:0] {
        rst_pulse_start, rst_pulse_high, rst_done
    } rst_state_t;

    // ns to clock ticks, with two extra ticks of margin.
    function automatic int ns_to_ticks(input int t_ns, input int period_ns);
        return t_ns / period_ns + 2;
    endfunction

endpackage

`default_nettype wire

// ==== design/chip_reset_gen.sv ====
// ******************************
// one reset pulse of t_reset_ticks + 1 clocks per user reset.
// ******************************
`timescale 1ns/1ps
`default_nettype none

module chip_reset_gen #(
    parameter ad7606_pkg::tick_t t_reset_ticks = 8'd4
) (
    input  wire  usr_clk,
    input  wire  usr_rst,
    output logic hw_reset,
    output logic reset_done
);
    import ad7606_pkg::*;

    rst_state_t state;
    tick_t      cnt;                        // pulse width counter.

    always_ff @(posedge usr_clk or negedge usr_rst) begin
        if (!usr_rst) begin
            state      <= rst_pulse_start;
            cnt        <= '0;
            hw_reset   <= 1'b0;
            reset_done <= 1'b0;
        end else begin
            case (state)
                rst_pulse_start: begin
                    hw_reset <= 1'b1;       // pulse starts.
                    cnt      <= '0;
                    state    <= rst_pulse_high;
                end
                rst_pulse_high: begin
                    if (cnt >= t_reset_ticks) begin
                        hw_reset <= 1'b0;   // end of pulse.
                        state    <= rst_done;
                    end else begin
                        cnt <= cnt + tick_t'(1);
                    end
                end
                rst_done: reset_done <= 1'b1;    // held until next reset.
                default:  state <= rst_done;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/conv_sequencer.sv ====
// ******************************
// triggers while a sample runs are dropped.
// owns cs# for the whole sample and the user status flags.
// ******************************
`timescale 1ns/1ps
`default_nettype none

module conv_sequencer #(
    parameter ad7606_pkg::tick_t t1_ticks       = 8'd4,
    parameter ad7606_pkg::tick_t t2_ticks       = 8'd3,
    parameter ad7606_pkg::tick_t busy_max_ticks = 8'd12
) (
    input  wire  usr_clk,
    input  wire  usr_rst,
    input  wire  trigger_rise,
    input  wire  reset_done,
    input  wire  busy_s,
    input  wire  read_done,
    input  wire  read_err,
    output logic hw_convst,
    output logic hw_cs,
    output logic read_start,
    output logic usr_complete,
    output logic usr_error,
    output logic usr_sampling
);
    import ad7606_pkg::*;

    seq_state_t state;
    tick_t      cnt;                        // delay and busy timeout.

    // ******************************
    // main sequence
    // ******************************
    always_ff @(posedge usr_clk or negedge usr_rst) begin
        if (!usr_rst) begin
            state        <= seq_idle;
            cnt          <= '0;
            hw_convst    <= 1'b1;
            hw_cs        <= 1'b1;
            read_start   <= 1'b0;
            usr_complete <= 1'b0;
            usr_error    <= 1'b0;
            usr_sampling <= 1'b0;
        end else begin
            read_start <= 1'b0;             // single cycle pulse.
            case (state)
                seq_idle: begin
                    if (trigger_rise && reset_done) begin
                        hw_cs        <= 1'b0;   // held low until sample ends.
                        hw_convst    <= 1'b0;   // start conversion.
                        usr_sampling <= 1'b1;
                        usr_complete <= 1'b0;
                        usr_error    <= 1'b0;
                        cnt          <= '0;
                        state        <= seq_convst_low;
                    end
                end
                seq_convst_low: begin
                    if (cnt >= t2_ticks) begin
                        hw_convst <= 1'b1;
                        cnt       <= '0;
                        state     <= seq_busy_rise_wait;
                    end else begin
                        cnt <= cnt + tick_t'(1);
                    end
                end
                seq_busy_rise_wait: begin
                    // give busy time to go high.
                    if (cnt >= t1_ticks) begin
                        cnt   <= '0;
                        state <= seq_busy_fall_wait;
                    end else begin
                        cnt <= cnt + tick_t'(1);
                    end
                end
                seq_busy_fall_wait: begin
                    if (!busy_s) begin
                        read_start <= 1'b1;     // conversion finished.
                        state      <= seq_reading;
                    end else if (cnt >= busy_max_ticks) begin
                        hw_cs        <= 1'b1;   // busy stuck.
                        usr_sampling <= 1'b0;
                        usr_complete <= 1'b1;
                        usr_error    <= 1'b1;
                        state        <= seq_idle;
                    end else begin
                        cnt <= cnt + tick_t'(1);
                    end
                end
                seq_reading: begin
                    if (read_done || read_err) begin
                        hw_cs        <= 1'b1;
                        usr_sampling <= 1'b0;
                        usr_complete <= 1'b1;
                        usr_error    <= read_err;
                        state        <= seq_idle;
                    end
                end
                default: state <= seq_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/input_sync.sv ====
// ******************************
// two flop synchronizers; all outputs lag their pins by two clocks.
// ******************************
`timescale 1ns/1ps
`default_nettype none

module input_sync (
    input  wire  usr_clk,
    input  wire  usr_rst,
    input  wire  usr_trigger,
    input  wire  hw_busy,
    input  wire  hw_first_data,
    output logic trigger_rise,
    output logic busy_s,
    output logic first_data_s
);
    logic [2:0] trig_hist;                  // [0] newest.
    logic [1:0] busy_sync;
    logic [1:0] fd_sync;

    always_ff @(posedge usr_clk or negedge usr_rst) begin
        if (!usr_rst) begin
            trig_hist <= 3'b000;
            busy_sync <= 2'b11;             // busy reads as converting.
            fd_sync   <= 2'b00;
        end else begin
            trig_hist <= {trig_hist[1:0], usr_trigger};
            busy_sync <= {busy_sync[0], hw_busy};
            fd_sync   <= {fd_sync[0], hw_first_data};
        end
    end

    assign trigger_rise = trig_hist[1] & ~trig_hist[2];    // rising edge.
    assign busy_s       = busy_sync[1];
    assign first_data_s = fd_sync[1];

endmodule

`default_nettype wire

// ==== design/parallel_reader.sv ====
// ******************************
// reads num_channels words per read_start; firstdata needed on word 0.
// on a firstdata timeout no channel register changes.
// ******************************
`timescale 1ns/1ps
`default_nettype none

module parallel_reader #(
    parameter ad7606_pkg::tick_t t10_ticks            = 8'd3,
    parameter ad7606_pkg::tick_t t11_ticks            = 8'd2,
    parameter ad7606_pkg::tick_t t14_ticks            = 8'd3,
    parameter ad7606_pkg::tick_t first_data_max_ticks = 8'd12
) (
    input  wire                      usr_clk,
    input  wire                      usr_rst,
    input  wire                      read_start,
    input  wire                      first_data_s,
    input  wire ad7606_pkg::sample_t hw_data,
    output logic                     hw_rd,
    output ad7606_pkg::sample_t      usr_channel [ad7606_pkg::num_channels],
    output logic                     read_done,
    output logic                     read_err
);
    import ad7606_pkg::*;

    localparam int idx_w = $clog2(num_channels);   // register select width.

    read_state_t state;
    chan_idx_t   idx;                       // next channel to capture.
    tick_t       cnt;                       // strobe timing and timeout.

    // ******************************
    // rd# strobes and capture
    // ******************************
    always_ff @(posedge usr_clk or negedge usr_rst) begin
        if (!usr_rst) begin
            state       <= rd_idle;
            idx         <= '0;
            cnt         <= '0;
            hw_rd       <= 1'b1;
            read_done   <= 1'b0;
            read_err    <= 1'b0;
            usr_channel <= '{default: '0};
        end else begin
            read_done <= 1'b0;
            read_err  <= 1'b0;
            case (state)
                rd_idle: begin
                    if (read_start) begin
                        idx   <= '0;
                        cnt   <= '0;
                        hw_rd <= 1'b1;
                        state <= rd_high;
                    end
                end
                rd_high: begin
                    if (cnt >= t11_ticks - tick_t'(1)) begin
                        hw_rd <= 1'b0;      // falling edge, chip drives bus.
                        cnt   <= '0;
                        state <= rd_data_settle;
                    end else begin
                        cnt <= cnt + tick_t'(1);
                    end
                end
                rd_data_settle: begin
                    if (cnt >= t14_ticks - tick_t'(1)) begin
                        cnt   <= '0;
                        state <= rd_capture;
                    end else begin
                        cnt <= cnt + tick_t'(1);
                    end
                end
                rd_capture: begin
                    if (idx == '0 && !first_data_s) begin
                        // word 0 must carry firstdata.
                        if (cnt >= first_data_max_ticks) begin
                            read_err <= 1'b1;
                            hw_rd    <= 1'b1;
                            state    <= rd_idle;
                        end else begin
                            cnt <= cnt + tick_t'(1);
                        end
                    end else begin
                        usr_channel[idx[idx_w-1:0]] <= hw_data;
                        idx   <= idx + chan_idx_t'(1);
                        cnt   <= '0;
                        state <= rd_low_hold;
                    end
                end
                rd_low_hold: begin
                    if (cnt >= t10_ticks - tick_t'(1)) begin
                        hw_rd <= 1'b1;      // end of strobe.
                        cnt   <= '0;
                        if (idx == chan_idx_t'(num_channels)) begin
                            read_done <= 1'b1;
                            state     <= rd_idle;
                        end else begin
                            state <= rd_high;
                        end
                    end else begin
                        cnt <= cnt + tick_t'(1);
                    end
                end
                default: state <= rd_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
design/ad7606_pkg.sv
design/input_sync.sv
design/chip_reset_gen.sv
design/conv_sequencer.sv
design/parallel_reader.sv
design/ad7606_ctrl.sv
tests/ad7606_model.sv
tests/tb_ad7606.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the testbench with verilator, run it, look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_ad7606 -f filelist.f \
    --Mdir obj_dir -o tb_ad7606

out="$(./obj_dir/tb_ad7606)"
echo "$out"

if grep -qx "Simulation completed successfully" <<< "$out"; then
    exit 0
else
    exit 1
fi

// ==== tests/ad7606_model.sv ====
// ******************************
// behavioral converter for the testbench; parallel mode, no real timing.
// outputs change 1 ns after usr_clk rises, word order is fixed v1..v8.
// ******************************
`timescale 1ns/1ps
`default_nettype none

module ad7606_model #(
    parameter int busy_cycles = 6           // conversion time in clocks.
) (
    input  wire         usr_clk,
    input  wire         hw_convst,
    input  wire         hw_rd,
    input  wire         busy_stuck,         // fault: busy never falls.
    input  wire         no_first_data,      // fault: firstdata stays low.
    input  logic [15:0] words [8],
    output logic        hw_busy,
    output logic        hw_first_data,
    output logic [15:0] hw_data
);
    logic       convst_q;                   // convst one clock ago.
    logic       rd_q;                       // rd# one clock ago.
    logic [2:0] word_idx;                   // next word on the bus.
    int         busy_left;

    initial begin
        hw_busy       = 1'b0;
        hw_first_data = 1'b0;
        hw_data       = '0;
        convst_q      = 1'b1;
        rd_q          = 1'b1;
        word_idx      = 3'd0;
        busy_left     = 0;
    end

    always @(posedge usr_clk) begin
        #1;
        if (!convst_q && hw_convst) begin   // conversion starts on convst rise.
            hw_busy       = 1'b1;
            hw_first_data = 1'b0;
            busy_left     = busy_cycles;
            word_idx      = 3'd0;
        end else if (busy_left > 0) begin
            busy_left = busy_left - 1;
        end else if (!busy_stuck) begin
            hw_busy = 1'b0;                 // conversion done.
        end
        if (rd_q && !hw_rd) begin           // rd# fell, next word out.
            hw_data       = words[word_idx];
            hw_first_data = (word_idx == 3'd0) && !no_first_data;
            word_idx      = word_idx + 3'd1;
        end
        convst_q = hw_convst;
        rd_q     = hw_rd;
    end

endmodule

`default_nettype wire

// ==== tests/tb_ad7606.sv ====
// ******************************
// directed tests of ad7606_ctrl at a 40 ns clock.
// ad7606_model stands in for the converter.
// ******************************
`timescale 1ns/1ps
`default_nettype none

module tb_ad7606;
    import ad7606_pkg::*;

    localparam int max_cycles = 6 * 500;    // six tests, 500 clocks each at most.

    logic    usr_clk;
    logic    usr_rst;
    logic    usr_trigger;
    sample_t chan [num_channels];
    logic    usr_complete;
    logic    usr_error;
    logic    usr_sampling;
    logic    usr_reset_done;
    logic    hw_busy;
    logic    hw_first_data;
    sample_t hw_data;
    logic    hw_convst;
    logic    hw_rd;
    logic    hw_cs;
    logic    hw_reset;
    logic    busy_stuck;                    // model fault modes.
    logic    no_first_data;
    sample_t preload [num_channels];        // words the model will return.
    sample_t expect_words [num_channels];   // last good sample.
    logic [15:0] lfsr;
    int value_errs = 0;
    int other_errs = 0;
    int cycles = 0;
    int rd_falls = 0;
    int convst_falls = 0;
    int reset_rises = 0;

    ad7606_ctrl #(.clk_period_ns(40)) u_dut (
        .usr_clk, .usr_rst, .usr_trigger, .usr_channel(chan), .usr_complete,
        .usr_error, .usr_sampling, .usr_reset_done, .hw_busy, .hw_first_data,
        .hw_data, .hw_convst, .hw_rd, .hw_cs, .hw_reset
    );

    ad7606_model u_model (
        .usr_clk, .hw_convst, .hw_rd, .busy_stuck, .no_first_data,
        .words(preload), .hw_busy, .hw_first_data, .hw_data
    );

    always #20 usr_clk = ~usr_clk;          // 40 ns period.

    always @(negedge hw_rd) rd_falls++;
    always @(negedge hw_convst) convst_falls++;
    always @(posedge hw_reset) reset_rises++;

    always @(posedge usr_clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout: run stopped after %0d cycles, a wait never ended", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // ******************************
    // helpers
    // ******************************
    task automatic next_cycle();
        @(posedge usr_clk);
        #2;                                 // drive and sample point.
    endtask

    task automatic idle(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic bit_equal(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            value_errs++;
            $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic word_equal(input string name, input sample_t got, input sample_t exp);
        assert (got === exp) else begin
            value_errs++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic require(input logic ok, input string what);
        assert (ok) else begin
            other_errs++;
            $display("at %0t: %s", $time, what);
        end
    endtask

    task automatic channels_equal();
        int i;
        for (i = 0; i < num_channels; i++) begin
            word_equal($sformatf("usr_channel[%0d]", i), chan[3'(i)], expect_words[3'(i)]);
        end
    endtask

    // fibonacci lfsr, taps 16 14 13 11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic fill_preload();
        int i;
        int b;
        for (i = 0; i < num_channels; i++) begin
            for (b = 0; b < 16; b++) begin
                lfsr = lfsr_next(lfsr);     // one step per bit.
                preload[3'(i)] = {preload[3'(i)][14:0], lfsr[0]};
            end
        end
    endtask

    task automatic apply_reset();
        next_cycle();
        usr_rst = 1'b0;
        idle(5);
        usr_rst = 1'b1;
    endtask

    // one trigger, then wait for usr_complete.
    task automatic run_sample(output int low_cycles, output logic cs_ok);
        low_cycles  = 0;
        cs_ok       = 1'b1;
        usr_trigger = 1'b1;
        while (!usr_sampling) next_cycle();
        usr_trigger = 1'b0;
        while (!usr_complete) begin
            if (!hw_convst) begin
                low_cycles++;
                if (hw_cs) cs_ok = 1'b0;    // cs# must cover convst.
            end
            next_cycle();
        end
    endtask

    // ******************************
    // tests
    // ******************************
    task automatic chip_reset_gating();
        int   high_cycles;
        int   base_rise;
        int   base_conv;
        logic done_early;
        logic sampled;
        high_cycles = 0;
        base_rise   = reset_rises;
        base_conv   = convst_falls;
        done_early  = 1'b0;
        sampled     = 1'b0;
        repeat (12) begin
            next_cycle();
            if (hw_reset) begin
                high_cycles++;
                if (usr_reset_done) done_early = 1'b1;
                if (high_cycles == 1) usr_trigger = 1'b1;  // edge inside the pulse.
                if (high_cycles == 3) usr_trigger = 1'b0;
            end
            if (usr_sampling) sampled = 1'b1;
        end
        usr_trigger = 1'b0;
        require(reset_rises - base_rise == 1, "hw_reset did not show exactly one pulse");
        require(high_cycles >= 3, $sformatf("hw_reset high only %0d cycles", high_cycles));
        require(!done_early, "usr_reset_done rose while hw_reset was high");
        bit_equal("usr_reset_done", usr_reset_done, 1'b1);
        bit_equal("hw_reset", hw_reset, 1'b0);
        require(convst_falls == base_conv, "trigger during chip reset pulsed convst");
        require(!sampled, "trigger during chip reset raised usr_sampling");
    endtask

    task automatic normal_sample();
        int   low;
        int   base;
        logic cs_ok;
        fill_preload();
        base = rd_falls;
        run_sample(low, cs_ok);
        expect_words = preload;
        channels_equal();
        bit_equal("usr_error", usr_error, 1'b0);
        bit_equal("usr_sampling", usr_sampling, 1'b0);
        bit_equal("hw_cs", hw_cs, 1'b1);
        bit_equal("hw_rd", hw_rd, 1'b1);
        require(low >= 2, $sformatf("convst low for %0d cycles, at least 2 needed", low));
        require(cs_ok, "cs# was high while convst was low");
        require(rd_falls - base == 8, $sformatf("%0d rd# falls, 8 needed", rd_falls - base));
    endtask

    task automatic busy_stuck_sample();
        int   low;
        int   base;
        logic cs_ok;
        busy_stuck = 1'b1;
        fill_preload();                     // must not reach the channels.
        base = rd_falls;
        run_sample(low, cs_ok);
        require(low >= 2, $sformatf("convst low for %0d cycles, at least 2 needed", low));
        require(cs_ok, "cs# was high while convst was low");
        bit_equal("usr_error", usr_error, 1'b1);
        channels_equal();
        require(rd_falls == base, "rd# strobed although busy never fell");
        busy_stuck = 1'b0;
        idle(3);
    endtask

    task automatic missing_first_data();
        int   low;
        logic cs_ok;
        no_first_data = 1'b1;
        fill_preload();
        run_sample(low, cs_ok);
        require(low >= 2, $sformatf("convst low for %0d cycles, at least 2 needed", low));
        require(cs_ok, "cs# was high while convst was low");
        bit_equal("usr_error", usr_error, 1'b1);
        channels_equal();
        bit_equal("hw_rd", hw_rd, 1'b1);
        bit_equal("hw_cs", hw_cs, 1'b1);
        no_first_data = 1'b0;
        idle(3);
    endtask

    task automatic recovery_sample();
        int   low;
        logic cs_ok;
        bit_equal("usr_error", usr_error, 1'b1);  // left from last fault.
        fill_preload();
        run_sample(low, cs_ok);
        expect_words = preload;
        require(low >= 2, $sformatf("convst low for %0d cycles, at least 2 needed", low));
        require(cs_ok, "cs# was high while convst was low");
        bit_equal("usr_error", usr_error, 1'b0);
        channels_equal();
        idle(3);
    endtask

    task automatic retrigger_ignored();
        int base;
        fill_preload();
        base        = convst_falls;
        usr_trigger = 1'b1;
        while (!usr_sampling) next_cycle();
        usr_trigger = 1'b0;
        idle(2);
        require(usr_sampling, "sample ended before the second trigger");
        usr_trigger = 1'b1;                 // second edge mid sample.
        idle(3);
        usr_trigger = 1'b0;
        while (!usr_complete) next_cycle();
        expect_words = preload;
        require(convst_falls - base == 1,
                $sformatf("%0d convst pulses for one sample", convst_falls - base));
        bit_equal("usr_error", usr_error, 1'b0);
        channels_equal();
    endtask

    initial begin
        usr_clk       = 1'b0;
        usr_rst       = 1'b1;
        usr_trigger   = 1'b0;
        busy_stuck    = 1'b0;
        no_first_data = 1'b0;
        lfsr          = 16'd27744;
        preload       = '{default: '0};
        expect_words  = '{default: '0};
        apply_reset();
        chip_reset_gating();
        normal_sample();
        busy_stuck_sample();
        missing_first_data();
        recovery_sample();
        retrigger_ignored();
        $display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
